// File: dma_controller.f
common/dma_pkg.sv
dma_engine/dma_config_regs.sv
dma_engine/dma_burst_engine.sv
verilog/dma_buffer_ram.sv
verilog/dma_controller.sv
test/dma_bus_slave.sv
test/dma_controller_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the DMA controller testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f dma_controller.f \
    --top-module dma_controller_tb -o sim_dma

output=$(./obj_dir/sim_dma 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

// File: test/dma_controller_tb.sv
// Testbench top for the DMA controller, runs register, buffer, read, write and error tests
`timescale 1ns/10ps

module dma_controller_tb;

    localparam logic [31:0] SEED = 32'h27bd_a1a9;
    localparam int POLL_LIMIT  = 3000;
    localparam int SLAVE_WORDS = 1024;

    logic clock, reset, ci_valid, ci_write, ci_done;
    dma_pkg::dma_sel_e ci_select;
    logic [31:0] ci_data, ci_wdata_hi, ci_result, bus_address_data, bus_in_address_data;
    logic bus_request, bus_grant, bus_begin, bus_read_n_write, bus_data_valid, bus_end;
    logic [7:0] bus_burst_size;
    logic [3:0] bus_byte_enable;
    logic bus_in_data_valid, bus_in_end, bus_in_busy, bus_in_error;
    logic [31:0] rng;
    logic [31:0] exp_addr [$];
    logic [7:0]  exp_size [$];
    logic [31:0] wexp [512];
    logic        exp_rnw;
    logic        check_begins;
    int          begin_cnt;
    int          end_cnt;

    dma_controller dma_controller_i (.*);

    dma_bus_slave bus_slave_i (.*);

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("ERROR %s got %h expected %h", name, got, exp);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // One processor access, ci_done must rise exactly one cycle after ci_valid
    task automatic access(dma_pkg::dma_sel_e sel, logic wr, logic [31:0] data,
                          logic [31:0] hi, output logic [31:0] result);
        @(posedge clock);
        #1 ci_valid = 1'b1;
        ci_select   = sel;
        ci_write    = wr;
        ci_data     = data;
        ci_wdata_hi = hi;
        @(negedge clock);
        assert (!ci_done) else report_failure("ci_done was high before its access completed");
        @(posedge clock);
        #1 ci_valid = 1'b0;
        ci_write = 1'b0;
        @(negedge clock);
        assert (ci_done) else report_failure("ci_done did not pulse one cycle after ci_valid");
        result = ci_result;
    endtask

    task automatic check_reg(dma_pkg::dma_sel_e sel, string name, logic [31:0] exp);
        logic [31:0] r;
        access(sel, 1'b0, 32'h0, 32'h0, r);
        assert (r === exp) else report_mismatch(name, r, exp);
    endtask

    task automatic run_block(dma_pkg::dma_mode_e mode, int idx, int mstart, int block,
                             int burst, logic expect_error);
        logic [31:0] r;
        int          off;
        int          polls;
        int          bursts;
        exp_addr.delete();
        exp_size.delete();
        bursts = 0;
        for (off = 0; off < block; off += burst + 1) begin
            exp_addr.push_back(32'(idx * 4 + off * 4));
            exp_size.push_back(8'(((block - off) < burst + 1 ? block - off : burst + 1) - 1));
            bursts++;
        end
        exp_rnw      = (mode == dma_pkg::mode_read);
        check_begins = !expect_error;
        begin_cnt    = 0;
        access(dma_pkg::sel_bus_start, 1'b1, 32'(idx * 4), 32'h0, r);
        access(dma_pkg::sel_mem_start, 1'b1, 32'(mstart), 32'h0, r);
        access(dma_pkg::sel_block_size, 1'b1, 32'(block), 32'h0, r);
        access(dma_pkg::sel_burst_size, 1'b1, 32'(burst), 32'h0, r);
        access(dma_pkg::sel_ctrl_status, 1'b1, 32'(mode), 32'h0, r);
        for (polls = 0; polls < POLL_LIMIT; polls++) begin
            access(dma_pkg::sel_ctrl_status, 1'b0, 32'h0, 32'h0, r);
            if (r != 32'(dma_pkg::status_busy))
                break;
        end
        if (polls == POLL_LIMIT)
            report_failure("Timeout waiting for the DMA block to finish");
        if (expect_error) begin
            assert (r == 32'(dma_pkg::status_error)) else report_mismatch("status", r, 2);
        end else begin
            assert (r == 32'(dma_pkg::status_idle)) else report_mismatch("status", r, 0);
            assert (begin_cnt == bursts) else report_mismatch("bus_begin count",
                                                              begin_cnt, bursts);
        end
        assert (!bus_slave_i.fault) else report_failure("Bus slave saw a broken burst");
    endtask

    // Each bus_begin is compared with the next burst computed from the block rule
    always @(negedge clock) begin
        if (!reset) begin
            if (bus_end)
                end_cnt++;
            if (bus_begin) begin
                begin_cnt++;
                if (check_begins) begin
                    assert (exp_addr.size() > 0) else report_failure("Unexpected extra bus_begin");
                    assert (bus_address_data === exp_addr[0])
                        else report_mismatch("bus_address_data", bus_address_data, exp_addr[0]);
                    assert (bus_burst_size === exp_size[0])
                        else report_mismatch("bus_burst_size", 32'(bus_burst_size),
                                             32'(exp_size[0]));
                    assert (bus_read_n_write === exp_rnw)
                        else report_mismatch("bus_read_n_write", 32'(bus_read_n_write),
                                             32'(exp_rnw));
                    assert (bus_byte_enable === 4'hf)
                        else report_mismatch("bus_byte_enable", 32'(bus_byte_enable), 32'hf);
                    void'(exp_addr.pop_front());
                    void'(exp_size.pop_front());
                end
            end
        end
    end

    task automatic check_read(int idx, int mstart, int block);
        logic [31:0] r;
        int          i;
        for (i = 0; i < block; i++) begin
            access(dma_pkg::sel_memory, 1'b0, 32'((mstart + i) % 512), 32'h0, r);
            assert (r === bus_slave_i.mem[(idx + i) % SLAVE_WORDS])
                else report_mismatch("buffer word", r, bus_slave_i.mem[(idx + i) % SLAVE_WORDS]);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] v;
        int          i;
        int          t;
        int          idx;
        int          ms;
        int          blk;
        int          bst;
        rng = SEED;
        reset = 1'b1;
        ci_valid = 1'b0;
        ci_write = 1'b0;
        ci_select = dma_pkg::sel_memory;
        ci_data = '0;
        ci_wdata_hi = '0;
        check_begins = 1'b0;
        begin_cnt = 0;
        end_cnt = 0;
        repeat (8) @(posedge clock);
        #1 reset = 1'b0;
        @(negedge clock);
        assert (!bus_request && !bus_begin && !bus_data_valid && !bus_end && !ci_done)
            else report_failure("Bus control outputs not low after reset");
        check_reg(dma_pkg::sel_bus_start, "bus_start", 0);
        check_reg(dma_pkg::sel_mem_start, "mem_start", 0);
        check_reg(dma_pkg::sel_block_size, "block_size", 0);
        check_reg(dma_pkg::sel_burst_size, "burst_size", 0);
        check_reg(dma_pkg::sel_ctrl_status, "status", 0);
        // Register read-back, masked to each width
        v = next_rand();
        access(dma_pkg::sel_bus_start, 1'b1, v, 32'h0, r);
        check_reg(dma_pkg::sel_bus_start, "bus_start", v);
        v = next_rand();
        access(dma_pkg::sel_mem_start, 1'b1, v, 32'h0, r);
        check_reg(dma_pkg::sel_mem_start, "mem_start", v & 32'h1ff);
        v = next_rand();
        access(dma_pkg::sel_block_size, 1'b1, v, 32'h0, r);
        check_reg(dma_pkg::sel_block_size, "block_size", v & 32'h3ff);
        v = next_rand();
        access(dma_pkg::sel_burst_size, 1'b1, v, 32'h0, r);
        check_reg(dma_pkg::sel_burst_size, "burst_size", v & 32'hff);
        for (i = 0; i < 16; i++) begin
            idx = int'(next_rand() % 512);
            v   = next_rand();
            access(dma_pkg::sel_memory, 1'b1, 32'(idx), v, r);
            access(dma_pkg::sel_memory, 1'b0, 32'(idx), 32'h0, r);
            assert (r === v) else report_mismatch("buffer word", r, v);
        end
        // Random reads, slave memory as the source
        for (i = 0; i < SLAVE_WORDS; i++)
            bus_slave_i.mem[i] = next_rand() ^ 32'(i);
        for (t = 0; t < 6; t++) begin
            idx = int'(next_rand() % SLAVE_WORDS);
            ms  = int'(next_rand() % 512);
            blk = int'(next_rand() % 200) + 1;
            bst = (t == 0) ? 255 : int'(next_rand() % 16);
            run_block(dma_pkg::mode_read, idx, ms, blk, bst, 1'b0);
            check_read(idx, ms, blk);
        end
        // Random writes under back-pressure
        for (t = 0; t < 6; t++) begin
            idx = int'(next_rand() % SLAVE_WORDS);
            ms  = int'(next_rand() % 512);
            blk = int'(next_rand() % 200) + 1;
            bst = int'(next_rand() % 16);
            for (i = 0; i < blk; i++) begin
                wexp[i] = next_rand();
                access(dma_pkg::sel_memory, 1'b1, 32'((ms + i) % 512), wexp[i], r);
            end
            run_block(dma_pkg::mode_write, idx, ms, blk, bst, 1'b0);
            for (i = 0; i < blk; i++)
                assert (bus_slave_i.mem[(idx + i) % SLAVE_WORDS] === wexp[i])
                    else report_mismatch("slave word", bus_slave_i.mem[(idx + i) % SLAVE_WORDS],
                                         wexp[i]);
        end
        // Bus error abort, then a clean restart
        bus_slave_i.error_at = 3;
        t = end_cnt;
        run_block(dma_pkg::mode_read, 100, 40, 40, 7, 1'b1);
        assert (end_cnt > t) else report_failure("No bus_end pulse after the bus error");
        run_block(dma_pkg::mode_read, 100, 40, 40, 7, 1'b0);
        check_read(100, 40, 40);
        $display("sim passed");
        $finish;
    end

endmodule

// File: test/dma_bus_slave.sv
// Testbench bus slave with a word memory, grants the bus and answers DMA read and write bursts
`timescale 1ns/10ps

module dma_bus_slave (
    input  logic                         clock,
    input  logic                         bus_request,
    input  logic                         bus_begin,
    input  logic [dma_pkg::BUS_W-1:0]    bus_address_data,
    input  logic [dma_pkg::BURST_W-1:0]  bus_burst_size,
    input  logic                         bus_read_n_write,
    input  logic                         bus_data_valid,
    output logic                         bus_grant,
    output logic [dma_pkg::BUS_W-1:0]    bus_in_address_data,
    output logic                         bus_in_data_valid,
    output logic                         bus_in_end,
    output logic                         bus_in_busy,
    output logic                         bus_in_error
);

    localparam int WRITE_GUARD = 2000;

    logic [31:0] mem [1024];
    logic [31:0] rng;
    // Word index in a burst at which to raise an error once, -1 for none
    int          error_at;
    logic        fault;

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    task automatic serve_burst();
        logic [9:0] base;
        int         n;
        int         cnt;
        int         guard;
        logic       is_read;
        repeat (next_rand() % 4) @(posedge clock);
        @(posedge clock);
        #1 bus_grant = 1'b1;
        @(posedge clock);
        #1 bus_grant = 1'b0;
        @(negedge clock);
        if (!bus_begin) begin
            fault = 1'b1;
            return;
        end
        base    = bus_address_data[11:2];
        n       = int'(bus_burst_size) + 1;
        is_read = bus_read_n_write;
        cnt     = 0;
        for (guard = 0; guard < WRITE_GUARD && cnt < n; guard++) begin
            @(posedge clock);
            #1;
            bus_in_data_valid = 1'b0;
            bus_in_end        = 1'b0;
            if (error_at == cnt) begin
                // Abort the burst with a single error cycle
                bus_in_error = 1'b1;
                bus_in_busy  = 1'b1;
                @(posedge clock);
                #1 bus_in_error = 1'b0;
                bus_in_busy = 1'b0;
                error_at    = -1;
                return;
            end
            if (is_read) begin
                if (next_rand() % 3 != 0) begin
                    bus_in_data_valid   = 1'b1;
                    bus_in_address_data = mem[base + 10'(cnt)];
                    bus_in_end          = (cnt == n - 1);
                    cnt++;
                end
            end else begin
                bus_in_busy = (next_rand() % 4 == 0);
                @(negedge clock);
                if (bus_data_valid && !bus_in_busy) begin
                    mem[base + 10'(cnt)] = bus_address_data;
                    cnt++;
                end
            end
        end
        if (cnt < n)
            fault = 1'b1;
        @(posedge clock);
        #1 bus_in_data_valid = 1'b0;
        bus_in_end  = 1'b0;
        bus_in_busy = 1'b0;
    endtask

    initial begin
        rng                 = 32'h27bd_a1a9;
        error_at            = -1;
        fault               = 1'b0;
        bus_grant           = 1'b0;
        bus_in_address_data = '0;
        bus_in_data_valid   = 1'b0;
        bus_in_end          = 1'b0;
        bus_in_busy         = 1'b0;
        bus_in_error        = 1'b0;
        forever begin
            @(negedge clock);
            if (bus_request)
                serve_burst();
        end
    end

endmodule

// File: verilog/dma_controller.sv
// DMA controller top joining registers, burst engine and buffer behind the processor port
`timescale 1ns/10ps

module dma_controller (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              ci_valid,
    input  dma_pkg::dma_sel_e                 ci_select,
    input  logic                              ci_write,
    input  logic [dma_pkg::BUS_W-1:0]         ci_data,
    input  logic [dma_pkg::BUS_W-1:0]         ci_wdata_hi,
    output logic [dma_pkg::BUS_W-1:0]         ci_result,
    output logic                              ci_done,
    output logic                              bus_request,
    input  logic                              bus_grant,
    output logic                              bus_begin,
    output logic [dma_pkg::BUS_W-1:0]         bus_address_data,
    output logic [dma_pkg::BURST_W-1:0]       bus_burst_size,
    output logic                              bus_read_n_write,
    output logic [dma_pkg::WORD_BYTES-1:0]    bus_byte_enable,
    output logic                              bus_data_valid,
    output logic                              bus_end,
    input  logic [dma_pkg::BUS_W-1:0]         bus_in_address_data,
    input  logic                              bus_in_data_valid,
    input  logic                              bus_in_end,
    input  logic                              bus_in_busy,
    input  logic                              bus_in_error
);

    logic [dma_pkg::BUS_W-1:0]      bus_start;
    logic [dma_pkg::MEM_AW-1:0]     mem_start;
    logic [dma_pkg::BLOCK_W-1:0]    block_size;
    logic [dma_pkg::BURST_W-1:0]    burst_size;
    logic [dma_pkg::BLOCK_W-1:0]    burst_count;
    dma_pkg::dma_mode_e             mode;
    logic [dma_pkg::BUS_W-1:0]      reg_rdata;
    logic                           done;
    logic                           error_seen;
    logic [dma_pkg::MEM_AW-1:0]     mem_addr;
    logic [dma_pkg::BUS_W-1:0]      mem_wdata;
    logic                           mem_we;
    logic [dma_pkg::BUS_W-1:0]      mem_rdata;
    logic                           a_we;
    logic [dma_pkg::BUS_W-1:0]      a_rdata;
    dma_pkg::dma_sel_e              sel_d;

    // Processor buffer access, address in the low bits of ci_data
    assign a_we = ci_valid && ci_write && (ci_select == dma_pkg::sel_memory);

    always_ff @(posedge clock) begin
        if (reset) begin
            ci_done <= 1'b0;
            sel_d   <= dma_pkg::sel_memory;
        end else begin
            ci_done <= ci_valid;
            if (ci_valid)
                sel_d <= ci_select;
        end
    end

    // Result follows the select of the access that just completed
    assign ci_result = (sel_d == dma_pkg::sel_memory) ? a_rdata : reg_rdata;

    dma_config_regs dma_config_regs_i (
        .clock       (clock),
        .reset       (reset),
        .ci_valid    (ci_valid),
        .ci_select   (ci_select),
        .ci_write    (ci_write),
        .ci_data     (ci_data),
        .done        (done),
        .error_seen  (error_seen),
        .bus_start   (bus_start),
        .mem_start   (mem_start),
        .block_size  (block_size),
        .burst_size  (burst_size),
        .burst_count (burst_count),
        .mode        (mode),
        .reg_rdata   (reg_rdata)
    );

    dma_burst_engine dma_burst_engine_i (
        .clock               (clock),
        .reset               (reset),
        .mode                (mode),
        .bus_start           (bus_start),
        .mem_start           (mem_start),
        .block_size          (block_size),
        .burst_size          (burst_size),
        .burst_count         (burst_count),
        .mem_rdata           (mem_rdata),
        .mem_addr            (mem_addr),
        .mem_wdata           (mem_wdata),
        .mem_we              (mem_we),
        .done                (done),
        .error_seen          (error_seen),
        .busy                (),
        .bus_grant           (bus_grant),
        .bus_in_address_data (bus_in_address_data),
        .bus_in_data_valid   (bus_in_data_valid),
        .bus_in_end          (bus_in_end),
        .bus_in_busy         (bus_in_busy),
        .bus_in_error        (bus_in_error),
        .bus_request         (bus_request),
        .bus_begin           (bus_begin),
        .bus_address_data    (bus_address_data),
        .bus_burst_size      (bus_burst_size),
        .bus_read_n_write    (bus_read_n_write),
        .bus_byte_enable     (bus_byte_enable),
        .bus_data_valid      (bus_data_valid),
        .bus_end             (bus_end)
    );

    dma_buffer_ram dma_buffer_ram_i (
        .clock   (clock),
        .a_addr  (ci_data[dma_pkg::MEM_AW-1:0]),
        .a_wdata (ci_wdata_hi),
        .a_we    (a_we),
        .a_rdata (a_rdata),
        .b_addr  (mem_addr),
        .b_wdata (mem_wdata),
        .b_we    (mem_we),
        .b_rdata (mem_rdata)
    );

endmodule

// File: verilog/dma_buffer_ram.sv
// True dual-port DMA buffer memory, processor on port A and burst engine on port B
`timescale 1ns/10ps

module dma_buffer_ram (
    input  logic                          clock,
    input  logic [dma_pkg::MEM_AW-1:0]    a_addr,
    input  logic [dma_pkg::BUS_W-1:0]     a_wdata,
    input  logic                          a_we,
    output logic [dma_pkg::BUS_W-1:0]     a_rdata,
    input  logic [dma_pkg::MEM_AW-1:0]    b_addr,
    input  logic [dma_pkg::BUS_W-1:0]     b_wdata,
    input  logic                          b_we,
    output logic [dma_pkg::BUS_W-1:0]     b_rdata
);

    logic [dma_pkg::BUS_W-1:0] mem [dma_pkg::MEM_DEPTH];

    // Port A, read returns the old word on a write
    always_ff @(posedge clock) begin
        if (a_we)
            mem[a_addr] <= a_wdata;
        a_rdata <= mem[a_addr];
    end

    // Port B
    always_ff @(posedge clock) begin
        if (b_we)
            mem[b_addr] <= b_wdata;
        b_rdata <= mem[b_addr];
    end

endmodule

// File: dma_engine/dma_burst_engine.sv
// Bus master FSM that splits a DMA block into bursts and moves words between bus and buffer
`timescale 1ns/10ps

module dma_burst_engine (
    input  logic                              clock,
    input  logic                              reset,
    input  dma_pkg::dma_mode_e                mode,
    input  logic [dma_pkg::BUS_W-1:0]         bus_start,
    input  logic [dma_pkg::MEM_AW-1:0]        mem_start,
    input  logic [dma_pkg::BLOCK_W-1:0]       block_size,
    input  logic [dma_pkg::BURST_W-1:0]       burst_size,
    input  logic [dma_pkg::BLOCK_W-1:0]       burst_count,
    input  logic [dma_pkg::BUS_W-1:0]         mem_rdata,
    output logic [dma_pkg::MEM_AW-1:0]        mem_addr,
    output logic [dma_pkg::BUS_W-1:0]         mem_wdata,
    output logic                              mem_we,
    output logic                              done,
    output logic                              error_seen,
    output logic                              busy,
    input  logic                              bus_grant,
    input  logic [dma_pkg::BUS_W-1:0]         bus_in_address_data,
    input  logic                              bus_in_data_valid,
    input  logic                              bus_in_end,
    input  logic                              bus_in_busy,
    input  logic                              bus_in_error,
    output logic                              bus_request,
    output logic                              bus_begin,
    output logic [dma_pkg::BUS_W-1:0]         bus_address_data,
    output logic [dma_pkg::BURST_W-1:0]       bus_burst_size,
    output logic                              bus_read_n_write,
    output logic [dma_pkg::WORD_BYTES-1:0]    bus_byte_enable,
    output logic                              bus_data_valid,
    output logic                              bus_end
);

    dma_pkg::dma_state_e              state;
    dma_pkg::dma_state_e              state_next;
    logic                             is_read;
    logic [dma_pkg::BUS_W-1:0]        bus_addr;
    logic [dma_pkg::MEM_AW-1:0]       mem_ptr;
    logic [dma_pkg::MEM_AW-1:0]       wr_addr;
    logic [dma_pkg::BLOCK_W-1:0]      words_left;
    logic [dma_pkg::BLOCK_W-1:0]      burst_idx;
    logic [dma_pkg::BURST_W:0]        word_cnt;
    logic [dma_pkg::BURST_W:0]        burst_words;
    logic [dma_pkg::BURST_W:0]        burst_len;
    logic [dma_pkg::BURST_W:0]        burst_last;
    logic                             take;
    logic                             last_burst;

    // Words in this burst, the last one shortened to what remains
    assign burst_words = burst_size + 1'b1;
    assign burst_len   = (words_left < dma_pkg::BLOCK_W'(burst_words))
                         ? words_left[dma_pkg::BURST_W:0] : burst_words;
    assign burst_last  = burst_len - 1'b1;
    assign last_burst  = (burst_idx + 1'b1 == burst_count);

    // Write word accepted by the slave
    assign take = (state == dma_pkg::st_write_burst) && !bus_in_busy;

    always_comb begin
        state_next = state;
        case (state)
            dma_pkg::st_idle:
                if (mode == dma_pkg::mode_read || mode == dma_pkg::mode_write)
                    state_next = dma_pkg::st_request;
            dma_pkg::st_request:
                if (bus_grant)
                    state_next = dma_pkg::st_begin;
            dma_pkg::st_begin:
                state_next = is_read ? dma_pkg::st_read_burst : dma_pkg::st_write_burst;
            dma_pkg::st_read_burst:
                if (bus_in_end)
                    state_next = dma_pkg::st_end_burst;
            dma_pkg::st_write_burst:
                if (take && word_cnt == burst_last)
                    state_next = dma_pkg::st_end_burst;
            dma_pkg::st_end_burst:
                state_next = last_burst ? dma_pkg::st_idle : dma_pkg::st_request;
            default:
                state_next = dma_pkg::st_idle;
        endcase
        if (bus_in_error && state != dma_pkg::st_error)
            state_next = dma_pkg::st_error;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= dma_pkg::st_idle;
            mem_we <= 1'b0;
        end else begin
            state  <= state_next;
            mem_we <= (state == dma_pkg::st_read_burst) && bus_in_data_valid;
        end
    end

    // Address and count datapath, loaded when a block starts
    always_ff @(posedge clock) begin
        mem_wdata <= bus_in_address_data;
        wr_addr   <= mem_ptr;
        case (state)
            dma_pkg::st_idle: begin
                is_read    <= (mode == dma_pkg::mode_read);
                bus_addr   <= bus_start;
                mem_ptr    <= mem_start;
                words_left <= block_size;
                burst_idx  <= '0;
            end
            dma_pkg::st_begin:
                word_cnt <= '0;
            dma_pkg::st_read_burst:
                if (bus_in_data_valid)
                    mem_ptr <= mem_ptr + 1'b1;
            dma_pkg::st_write_burst:
                if (take) begin
                    mem_ptr  <= mem_ptr + 1'b1;
                    word_cnt <= word_cnt + 1'b1;
                end
            dma_pkg::st_end_burst: begin
                bus_addr   <= bus_addr
                              + dma_pkg::BUS_W'(burst_len) * dma_pkg::BUS_W'(dma_pkg::WORD_BYTES);
                words_left <= words_left - burst_len;
                burst_idx  <= burst_idx + 1'b1;
            end
            default: ;
        endcase
    end

    // Reads write behind the bus, writes prefetch the next word on each take
    assign mem_addr = is_read ? wr_addr : (take ? mem_ptr + 1'b1 : mem_ptr);

    assign done       = (state == dma_pkg::st_end_burst) && last_burst;
    assign error_seen = (state == dma_pkg::st_error);
    assign busy       = (state != dma_pkg::st_idle);

    assign bus_request      = (state == dma_pkg::st_request);
    assign bus_begin        = (state == dma_pkg::st_begin);
    assign bus_burst_size   = bus_begin ? burst_last[dma_pkg::BURST_W-1:0] : '0;
    assign bus_read_n_write = bus_begin && is_read;
    assign bus_byte_enable  = '1;
    assign bus_data_valid   = (state == dma_pkg::st_write_burst);
    assign bus_end          = (state == dma_pkg::st_error)
                              || ((state == dma_pkg::st_end_burst) && !is_read);

    always_comb begin
        if (bus_begin)
            bus_address_data = bus_addr;
        else if (bus_data_valid)
            bus_address_data = mem_rdata;
        else
            bus_address_data = '0;
    end

endmodule

// File: dma_engine/dma_config_regs.sv
// DMA configuration and status registers, written and read back by the processor strobe port
`timescale 1ns/10ps

module dma_config_regs (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              ci_valid,
    input  dma_pkg::dma_sel_e                 ci_select,
    input  logic                              ci_write,
    input  logic [dma_pkg::BUS_W-1:0]         ci_data,
    input  logic                              done,
    input  logic                              error_seen,
    output logic [dma_pkg::BUS_W-1:0]         bus_start,
    output logic [dma_pkg::MEM_AW-1:0]        mem_start,
    output logic [dma_pkg::BLOCK_W-1:0]       block_size,
    output logic [dma_pkg::BURST_W-1:0]       burst_size,
    output logic [dma_pkg::BLOCK_W-1:0]       burst_count,
    output dma_pkg::dma_mode_e                mode,
    output logic [dma_pkg::BUS_W-1:0]         reg_rdata
);

    dma_pkg::dma_status_e         status;
    dma_pkg::dma_mode_e           new_mode;
    logic [dma_pkg::BLOCK_W:0]    count_num;
    logic [dma_pkg::BLOCK_W:0]    count_den;
    logic [dma_pkg::BLOCK_W:0]    count_quot;

    assign new_mode = dma_pkg::dma_mode_e'(ci_data[1:0]);

    // Bursts per block, rounded up
    always_comb begin
        count_num   = block_size + burst_size;
        count_den   = burst_size + 1'b1;
        count_quot  = count_num / count_den;
        burst_count = count_quot[dma_pkg::BLOCK_W-1:0];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bus_start  <= '0;
            mem_start  <= '0;
            block_size <= '0;
            burst_size <= '0;
            mode       <= dma_pkg::mode_idle;
            status     <= dma_pkg::status_idle;
        end else begin
            if (ci_valid && ci_write) begin
                case (ci_select)
                    dma_pkg::sel_bus_start:  bus_start  <= ci_data;
                    dma_pkg::sel_mem_start:  mem_start  <= ci_data[dma_pkg::MEM_AW-1:0];
                    dma_pkg::sel_block_size: block_size <= ci_data[dma_pkg::BLOCK_W-1:0];
                    dma_pkg::sel_burst_size: burst_size <= ci_data[dma_pkg::BURST_W-1:0];
                    dma_pkg::sel_ctrl_status: begin
                        // Only a real copy with words to move starts the engine
                        if ((new_mode == dma_pkg::mode_read || new_mode == dma_pkg::mode_write)
                                && block_size != '0) begin
                            mode   <= new_mode;
                            status <= dma_pkg::status_busy;
                        end else begin
                            mode <= dma_pkg::mode_idle;
                        end
                    end
                    default: ;
                endcase
            end
            // Engine reports win over a same-cycle write
            if (error_seen) begin
                mode   <= dma_pkg::mode_idle;
                status <= dma_pkg::status_error;
            end else if (done) begin
                mode   <= dma_pkg::mode_idle;
                status <= dma_pkg::status_idle;
            end
        end
    end

    // Read-back lines up with ci_done
    always_ff @(posedge clock) begin
        if (reset) begin
            reg_rdata <= '0;
        end else if (ci_valid && !ci_write) begin
            case (ci_select)
                dma_pkg::sel_bus_start:   reg_rdata <= bus_start;
                dma_pkg::sel_mem_start:   reg_rdata <= dma_pkg::BUS_W'(mem_start);
                dma_pkg::sel_block_size:  reg_rdata <= dma_pkg::BUS_W'(block_size);
                dma_pkg::sel_burst_size:  reg_rdata <= dma_pkg::BUS_W'(burst_size);
                dma_pkg::sel_ctrl_status: reg_rdata <= dma_pkg::BUS_W'(status);
                default:                  reg_rdata <= '0;
            endcase
        end
    end

endmodule

// File: common/dma_pkg.sv
// Shared widths, buffer size and enums for the DMA controller RTL and its testbench
package dma_pkg;

    // Bus word and buffer geometry
    localparam int BUS_W      = 32;
    localparam int MEM_AW     = 9;
    localparam int MEM_DEPTH  = 512;
    localparam int WORD_BYTES = 4;

    // Block size counts words, burst size is words per burst minus one
    localparam int BLOCK_W = 10;
    localparam int BURST_W = 8;

    // Processor register select
    typedef enum logic [2:0] {
        sel_memory      = 3'd0,
        sel_bus_start   = 3'd1,
        sel_mem_start   = 3'd2,
        sel_block_size  = 3'd3,
        sel_burst_size  = 3'd4,
        sel_ctrl_status = 3'd5
    } dma_sel_e;

    // Control word
    typedef enum logic [1:0] {
        mode_idle  = 2'd0,
        mode_read  = 2'd1,
        mode_write = 2'd2
    } dma_mode_e;

    // Status word
    typedef enum logic [1:0] {
        status_idle  = 2'd0,
        status_busy  = 2'd1,
        status_error = 2'd2
    } dma_status_e;

    // Burst engine states
    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_request     = 3'd1,
        st_begin       = 3'd2,
        st_read_burst  = 3'd3,
        st_write_burst = 3'd4,
        st_end_burst   = 3'd5,
        st_error       = 3'd6
    } dma_state_e;

endpackage
